// ==== hdl/iq_alu.sv ====
`timescale 1ns/1ps
`include "issue_settings.svh"

module iq_alu (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  logic                            enq_req_0,
    input  logic                            enq_req_1,
    input  issue_pkg::ALU_Queue_Meta        din_0,
    input  issue_pkg::ALU_Queue_Meta        din_1,
    input  logic                            deq_req_0,
    input  logic                            deq_req_1,
    input  logic [`ALU_QUEUE_IDX_LEN-2:0]   deq0_idx,
    input  logic [`ALU_QUEUE_IDX_LEN-2:0]   deq1_idx,
    input  issue_pkg::Wake_Info             wake_Info,
    output logic [`ALU_QUEUE_LEN-1:0]       ready_vec,
    output logic [`ALU_QUEUE_LEN-1:0]       valid_vec,
    output issue_pkg::ALU_Queue_Meta        dout_0,
    output issue_pkg::ALU_Queue_Meta        dout_1,
    output logic                            almost_full,
    output logic                            full
);

    import issue_pkg::*;

    localparam int IDX_W = `ALU_QUEUE_IDX_LEN - 1;
    localparam int CNT_W = `ALU_QUEUE_IDX_LEN;
    localparam logic [CNT_W-1:0] QUEUE_LEN = CNT_W'(`ALU_QUEUE_LEN);

    ALU_Queue_Meta              entries [`ALU_QUEUE_LEN];
    logic [`ALU_QUEUE_LEN-1:0]  valid;

    logic [IDX_W-1:0]   free_idx_0;
    logic [IDX_W-1:0]   free_idx_1;
    logic               free_found_0;
    logic               free_found_1;

    logic               wr_en_0;
    logic               wr_en_1;
    logic [IDX_W-1:0]   wr_idx_0;
    logic [IDX_W-1:0]   wr_idx_1;

    logic [CNT_W-1:0]   valid_cnt;

    // True when tag matches an enabled broadcast
    function automatic logic tag_hit(input PRFNum tag, input Wake_Info w);
        return (w.wake_en_0 && (w.wake_reg_0 == tag)) ||
               (w.wake_en_1 && (w.wake_reg_1 == tag));
    endfunction

    function automatic ALU_Queue_Meta apply_wake(input ALU_Queue_Meta e, input Wake_Info w);
        ALU_Queue_Meta r;
        r = e;
        r.src1_rdy = e.src1_rdy | tag_hit(e.ops.src1PAddr, w);
        r.src2_rdy = e.src2_rdy | tag_hit(e.ops.src2PAddr, w);
        return r;
    endfunction

    // Two lowest free slots in one pass
    always_comb begin
        free_idx_0   = '0;
        free_idx_1   = '0;
        free_found_0 = 1'b0;
        free_found_1 = 1'b0;
        for (int i = 0; i < `ALU_QUEUE_LEN; i++) begin
            if (!valid[i]) begin
                if (!free_found_0) begin
                    free_idx_0   = IDX_W'(i);
                    free_found_0 = 1'b1;
                end else if (!free_found_1) begin
                    free_idx_1   = IDX_W'(i);
                    free_found_1 = 1'b1;
                end
            end
        end
    end

    // Slot 1 alone takes the lowest free entry
    assign wr_idx_0 = free_idx_0;
    assign wr_idx_1 = enq_req_0 ? free_idx_1 : free_idx_0;
    assign wr_en_0  = enq_req_0 && free_found_0 && !flush;
    assign wr_en_1  = enq_req_1 && !flush && (enq_req_0 ? free_found_1 : free_found_0);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else begin
            if (deq_req_0) valid[deq0_idx] <= 1'b0;
            if (deq_req_1) valid[deq1_idx] <= 1'b0;
            if (wr_en_0)   valid[wr_idx_0] <= 1'b1;
            if (wr_en_1)   valid[wr_idx_1] <= 1'b1;
        end
    end

    // Entry payload and source ready bits
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ALU_QUEUE_LEN; i++) begin
            if (wr_en_0 && (wr_idx_0 == IDX_W'(i))) begin
                entries[i] <= apply_wake(din_0, wake_Info);
            end else if (wr_en_1 && (wr_idx_1 == IDX_W'(i))) begin
                entries[i] <= apply_wake(din_1, wake_Info);
            end else if (valid[i]) begin
                entries[i] <= apply_wake(entries[i], wake_Info);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ALU_QUEUE_LEN; i++) begin
            ready_vec[i] = entries[i].src1_rdy & entries[i].src2_rdy;
        end
    end

    assign valid_vec = flush ? '0 : valid;   // Nothing issues during flush

    assign dout_0 = entries[deq0_idx];
    assign dout_1 = entries[deq1_idx];

    always_comb begin
        valid_cnt = '0;
        for (int i = 0; i < `ALU_QUEUE_LEN; i++) begin
            valid_cnt = valid_cnt + CNT_W'(valid[i]);
        end
    end

    assign full        = (valid_cnt == QUEUE_LEN);
    assign almost_full = (valid_cnt >= QUEUE_LEN - CNT_W'(1));   // Fewer than two free

endmodule

// ==== hdl/issue_alu.sv ====
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_alu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  issue_pkg::Wake_Info         wake_Info,
    input  issue_pkg::ALU_Queue_Meta    inst_Ops_0,
    input  issue_pkg::ALU_Queue_Meta    inst_Ops_1,
    input  logic                        enq_req_0,
    input  logic                        enq_req_1,
    output issue_pkg::UOPBundle         issue_info_0,
    output issue_pkg::UOPBundle         issue_info_1,
    output logic                        issue_en_0,
    output logic                        issue_en_1,
    output issue_pkg::PRFNum            wake_reg_0,
    output issue_pkg::PRFNum            wake_reg_1,
    output logic                        wake_reg_0_en,
    output logic                        wake_reg_1_en,
    output logic                        ready
);

    import issue_pkg::*;

    logic [`ALU_QUEUE_LEN-1:0]      ready_vec;
    logic [`ALU_QUEUE_LEN-1:0]      valid_vec;
    logic [`ALU_QUEUE_LEN-1:0]      arbit_vec;
    logic [`ALU_QUEUE_IDX_LEN-2:0]  sel0;
    logic [`ALU_QUEUE_IDX_LEN-2:0]  sel1;
    logic                           sel0_valid;
    logic                           sel1_valid;
    logic                           almost_full;
    logic                           full;
    ALU_Queue_Meta                  queue_dout_0;
    ALU_Queue_Meta                  queue_dout_1;

    iq_alu u_iq_alu (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .enq_req_0   (enq_req_0),
        .enq_req_1   (enq_req_1),
        .din_0       (inst_Ops_0),
        .din_1       (inst_Ops_1),
        .deq_req_0   (sel0_valid),
        .deq_req_1   (sel1_valid),
        .deq0_idx    (sel0),
        .deq1_idx    (sel1),
        .wake_Info   (wake_Info),
        .ready_vec   (ready_vec),
        .valid_vec   (valid_vec),
        .dout_0      (queue_dout_0),
        .dout_1      (queue_dout_1),
        .almost_full (almost_full),
        .full        (full)
    );

    // Valid entries with both sources ready
    assign arbit_vec = ready_vec & valid_vec;

    issue_arbiter_8 u_issue_arbiter_8 (
        .rdys       (arbit_vec),
        .sel0       (sel0),
        .sel1       (sel1),
        .sel0_valid (sel0_valid),
        .sel1_valid (sel1_valid),
        .sel_valid  ()
    );

    assign issue_info_0 = queue_dout_0.ops;
    assign issue_info_1 = queue_dout_1.ops;
    assign issue_en_0   = sel0_valid;
    assign issue_en_1   = sel1_valid;

    // Destination tags broadcast to consumers
    assign wake_reg_0    = queue_dout_0.ops.dstPAddr;
    assign wake_reg_1    = queue_dout_1.ops.dstPAddr;
    assign wake_reg_0_en = sel0_valid & queue_dout_0.ops.dstwe;
    assign wake_reg_1_en = sel1_valid & queue_dout_1.ops.dstwe;

    assign ready = ~(almost_full | full);   // Room for two more

endmodule

// ==== hdl/issue_arbiter_8.sv ====
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_arbiter_8 (
    input  logic [`ALU_QUEUE_LEN-1:0]       rdys,
    output logic [`ALU_QUEUE_IDX_LEN-2:0]   sel0,
    output logic [`ALU_QUEUE_IDX_LEN-2:0]   sel1,
    output logic                            sel0_valid,
    output logic                            sel1_valid,
    output logic                            sel_valid
);

    localparam int IDX_W = `ALU_QUEUE_IDX_LEN - 1;

    logic [`ALU_QUEUE_LEN-1:0] rdys_masked;

    // Index of lowest set bit or zero when none
    function automatic logic [IDX_W-1:0] lowest_set(input logic [`ALU_QUEUE_LEN-1:0] v);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = `ALU_QUEUE_LEN - 1; i >= 0; i--) begin
            if (v[i]) idx = IDX_W'(i);
        end
        return idx;
    endfunction

    // First winner
    assign sel0       = lowest_set(rdys);
    assign sel0_valid = |rdys;

    // Second winner with the first masked off
    assign rdys_masked = rdys & ~(`ALU_QUEUE_LEN'(1) << sel0);
    assign sel1        = lowest_set(rdys_masked);
    assign sel1_valid  = |rdys_masked;

    assign sel_valid = sel0_valid;

endmodule

// ==== hdl/issue_pkg.sv ====
`include "issue_settings.svh"

package issue_pkg;

    typedef logic [`PRF_TAG_LEN-1:0] PRFNum;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } alu_op_e;

    // Decoded ALU micro-op
    typedef struct packed {
        logic [5:0]  rob_idx;
        alu_op_e     op;
        PRFNum       src1PAddr;
        PRFNum       src2PAddr;
        PRFNum       dstPAddr;
        logic        dstwe;      // Writes a destination register
        logic [31:0] imm;
    } UOPBundle;

    typedef struct packed {
        UOPBundle ops;
        logic     src1_rdy;
        logic     src2_rdy;
    } ALU_Queue_Meta;

    // Two wakeup broadcast ports
    typedef struct packed {
        PRFNum wake_reg_0;
        logic  wake_en_0;
        PRFNum wake_reg_1;
        logic  wake_en_1;
    } Wake_Info;

endpackage

// ==== hdl/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// ALU issue queue depth
`define ALU_QUEUE_LEN 8

// Entry index is one bit narrower than this
`define ALU_QUEUE_IDX_LEN 4

// 64 physical registers
`define PRF_TAG_LEN 6

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module issue_alu_tb -f verilog.f -o issue_alu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/issue_alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    echo "RESULT: FAIL" >> "$LOG"
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== verification/issue_alu_chk.sv ====
`timescale 1ns/1ps

module issue_alu_chk (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic issue_en_0,
    input logic issue_en_1,
    input logic wake_reg_0_en,
    input logic wake_reg_1_en,
    input logic ready
);

    // Slot 1 only issues alongside slot 0
    a_slot_order: assert property (@(posedge clk) disable iff (rst)
        issue_en_1 |-> issue_en_0)
        else $error("issue_en_1 high without issue_en_0");

    a_no_issue_on_flush: assert property (@(posedge clk) disable iff (rst)
        flush |-> !issue_en_0 && !issue_en_1)
        else $error("issue during flush");

    a_wake_0: assert property (@(posedge clk) disable iff (rst)
        wake_reg_0_en |-> issue_en_0)
        else $error("wake_reg_0_en without issue_en_0");

    a_wake_1: assert property (@(posedge clk) disable iff (rst)
        wake_reg_1_en |-> issue_en_1)
        else $error("wake_reg_1_en without issue_en_1");

    // First cycle out of reset is idle with room
    a_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !issue_en_0 && !issue_en_1 && ready)
        else $error("issue or not ready right after reset");

endmodule

bind issue_alu issue_alu_chk u_issue_alu_chk (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .issue_en_0    (issue_en_0),
    .issue_en_1    (issue_en_1),
    .wake_reg_0_en (wake_reg_0_en),
    .wake_reg_1_en (wake_reg_1_en),
    .ready         (ready)
);

// ==== verification/issue_alu_tb.sv ====
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_alu_tb;

    import issue_pkg::*;

    localparam int N       = `ALU_QUEUE_LEN;
    localparam int TIMEOUT = 40;

    logic           clk;
    logic           rst;
    logic           flush;
    Wake_Info       wake_Info;
    ALU_Queue_Meta  inst_Ops_0;
    ALU_Queue_Meta  inst_Ops_1;
    logic           enq_req_0;
    logic           enq_req_1;
    UOPBundle       issue_info_0;
    UOPBundle       issue_info_1;
    logic           issue_en_0;
    logic           issue_en_1;
    PRFNum          wake_reg_0;
    PRFNum          wake_reg_1;
    logic           wake_reg_0_en;
    logic           wake_reg_1_en;
    logic           ready;

    ALU_Queue_Meta  m_ent [N];   // Reference queue
    logic [N-1:0]   m_valid;

    logic [31:0]    lfsr;
    int             errors;
    int             checks;
    int             wake_errors;
    int             tests_run;
    int             tests_failed;
    int             cycle_cnt;
    PRFNum          loop_reg_0;
    logic           loop_en_0;

    issue_alu uut (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .wake_Info     (wake_Info),
        .inst_Ops_0    (inst_Ops_0),
        .inst_Ops_1    (inst_Ops_1),
        .enq_req_0     (enq_req_0),
        .enq_req_1     (enq_req_1),
        .issue_info_0  (issue_info_0),
        .issue_info_1  (issue_info_1),
        .issue_en_0    (issue_en_0),
        .issue_en_1    (issue_en_1),
        .wake_reg_0    (wake_reg_0),
        .wake_reg_1    (wake_reg_1),
        .wake_reg_0_en (wake_reg_0_en),
        .wake_reg_1_en (wake_reg_1_en),
        .ready         (ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic ALU_Queue_Meta rand_op(input int tag_bits);
        ALU_Queue_Meta m;
        m.ops.rob_idx   = 6'(rand_bits(6));
        m.ops.op        = alu_op_e'(4'(rand_bits(3)));
        m.ops.src1PAddr = `PRF_TAG_LEN'(rand_bits(tag_bits));
        m.ops.src2PAddr = `PRF_TAG_LEN'(rand_bits(tag_bits));
        m.ops.dstPAddr  = `PRF_TAG_LEN'(rand_bits(tag_bits));
        m.ops.dstwe     = 1'(rand_bits(1));
        m.ops.imm       = rand_bits(32);
        m.src1_rdy      = 1'(rand_bits(1));
        m.src2_rdy      = 1'(rand_bits(1));
        return m;
    endfunction

    function automatic logic wake_match(input PRFNum tag, input Wake_Info w);
        return (w.wake_en_0 && (w.wake_reg_0 == tag)) || (w.wake_en_1 && (w.wake_reg_1 == tag));
    endfunction

    // Two or more free entries
    function automatic logic model_ready();
        int cnt;
        cnt = 0;
        for (int i = 0; i < N; i++) begin
            cnt = cnt + int'(m_valid[i]);
        end
        return cnt <= N - 2;
    endfunction

    task automatic expect_val(input string name, input logic [63:0] got,
                              input logic [63:0] exp, input bit is_wake);
        checks++;
        if (got !== exp) begin
            errors++;
            if (is_wake) wake_errors++;
            $display("Fail %s: got %h, expected %h (cycle %0d)", name, got, exp, cycle_cnt);
        end
    endtask

    task automatic model_enqueue(input int idx, input ALU_Queue_Meta op);
        m_ent[idx]          = op;
        m_ent[idx].src1_rdy = op.src1_rdy | wake_match(op.ops.src1PAddr, wake_Info);
        m_ent[idx].src2_rdy = op.src2_rdy | wake_match(op.ops.src2PAddr, wake_Info);
        m_valid[idx]        = 1'b1;
    endtask

    // Compare this cycle's outputs, then advance the model across the edge
    task automatic check_cycle();
        logic p0;
        logic p1;
        int   k0;
        int   k1;
        int   f0;
        int   f1;
        int   nf;
        p0 = 1'b0;
        p1 = 1'b0;
        k0 = 0;
        k1 = 0;
        if (rst) begin
            m_valid = '0;
        end else begin
            if (!flush) begin
                for (int i = 0; i < N; i++) begin
                    if (m_valid[i] && m_ent[i].src1_rdy && m_ent[i].src2_rdy) begin
                        if (!p0) begin
                            p0 = 1'b1;
                            k0 = i;
                        end else if (!p1) begin
                            p1 = 1'b1;
                            k1 = i;
                        end
                    end
                end
            end
            expect_val("ready", 64'(ready), 64'(model_ready()), 1'b0);
            expect_val("issue_en_0", 64'(issue_en_0), 64'(p0), 1'b0);
            expect_val("issue_en_1", 64'(issue_en_1), 64'(p1), 1'b0);
            if (p0) expect_val("issue_info_0", 64'(issue_info_0), 64'(m_ent[k0].ops), 1'b0);
            if (p1) expect_val("issue_info_1", 64'(issue_info_1), 64'(m_ent[k1].ops), 1'b0);
            expect_val("wake_reg_0_en", 64'(wake_reg_0_en), 64'(p0 & m_ent[k0].ops.dstwe), 1'b1);
            expect_val("wake_reg_1_en", 64'(wake_reg_1_en), 64'(p1 & m_ent[k1].ops.dstwe), 1'b1);
            if (p0) expect_val("wake_reg_0", 64'(wake_reg_0), 64'(m_ent[k0].ops.dstPAddr), 1'b1);
            if (p1) expect_val("wake_reg_1", 64'(wake_reg_1), 64'(m_ent[k1].ops.dstPAddr), 1'b1);
            loop_reg_0 = wake_reg_0;
            loop_en_0  = wake_reg_0_en;
            if (flush) begin
                m_valid = '0;
            end else begin
                f0 = -1;
                f1 = -1;
                for (int i = 0; i < N; i++) begin
                    if (!m_valid[i]) begin
                        if (f0 < 0) f0 = i;
                        else if (f1 < 0) f1 = i;
                    end else begin
                        m_ent[i].src1_rdy |= wake_match(m_ent[i].ops.src1PAddr, wake_Info);
                        m_ent[i].src2_rdy |= wake_match(m_ent[i].ops.src2PAddr, wake_Info);
                    end
                end
                if (p0) m_valid[k0] = 1'b0;
                if (p1) m_valid[k1] = 1'b0;
                nf = f0;
                if (enq_req_0 && f0 >= 0) begin
                    model_enqueue(f0, inst_Ops_0);
                    nf = f1;
                end
                if (enq_req_1 && nf >= 0) model_enqueue(nf, inst_Ops_1);
            end
        end
    endtask

    task automatic sample();
        @(negedge clk);
        cycle_cnt++;
        check_cycle();
    endtask

    task automatic idle_inputs();
        enq_req_0 <= 1'b0;
        enq_req_1 <= 1'b0;
        flush     <= 1'b0;
        wake_Info <= '0;
    endtask

    task automatic finish_test(input string name, input int fails);
        tests_run++;
        if (fails == 0) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, fails);
        end
    endtask

    initial begin
        ALU_Queue_Meta a;
        ALU_Queue_Meta b;
        Wake_Info      w;
        int            start;
        int            n;
        int            pairs;
        logic          en_ok;

        lfsr         = 32'h5d0b;
        errors       = 0;
        checks       = 0;
        wake_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        loop_reg_0   = '0;
        loop_en_0    = 1'b0;
        m_valid      = '0;
        rst          = 1'b1;
        flush        = 1'b0;
        enq_req_0    = 1'b0;
        enq_req_1    = 1'b0;
        wake_Info    = '0;
        inst_Ops_0   = '0;
        inst_Ops_1   = '0;

        @(posedge clk);
        repeat (4) begin
            sample();
            @(posedge clk);
        end
        rst <= 1'b0;

        // Test 1 covers idle after reset and two ready ops issuing together
        start = errors;
        sample();
        expect_val("ready", 64'(ready), 64'd1, 1'b0);
        expect_val("issue_en_0", 64'(issue_en_0), 64'd0, 1'b0);
        @(posedge clk);
        a = rand_op(6);
        b = rand_op(6);
        a.src1_rdy = 1'b1;
        a.src2_rdy = 1'b1;
        b.src1_rdy = 1'b1;
        b.src2_rdy = 1'b1;
        inst_Ops_0 <= a;
        inst_Ops_1 <= b;
        enq_req_0  <= 1'b1;
        enq_req_1  <= 1'b1;
        sample();
        @(posedge clk);
        idle_inputs();
        sample();
        expect_val("issue_en_0", 64'(issue_en_0), 64'd1, 1'b0);
        expect_val("issue_en_1", 64'(issue_en_1), 64'd1, 1'b0);
        expect_val("issue_info_0", 64'(issue_info_0), 64'(a.ops), 1'b0);
        expect_val("issue_info_1", 64'(issue_info_1), 64'(b.ops), 1'b0);
        @(posedge clk);
        finish_test("reset and paired issue", errors - start);

        // Test 2 holds a blocked op until both source tags wake
        start = errors;
        a = rand_op(6);
        a.ops.src1PAddr = 6'd40;
        a.ops.src2PAddr = 6'd41;
        a.src1_rdy      = 1'b0;
        a.src2_rdy      = 1'b0;
        inst_Ops_0 <= a;
        enq_req_0  <= 1'b1;
        sample();
        @(posedge clk);
        idle_inputs();
        repeat (5) begin
            sample();
            expect_val("issue_en_0", 64'(issue_en_0), 64'd0, 1'b0);
            @(posedge clk);
        end
        w = '0;
        w.wake_reg_0 = 6'd40;
        w.wake_en_0  = 1'b1;
        wake_Info <= w;
        sample();
        @(posedge clk);
        w.wake_reg_0 = 6'd41;
        wake_Info <= w;
        sample();
        expect_val("issue_en_0", 64'(issue_en_0), 64'd0, 1'b0);   // One source still waiting
        @(posedge clk);
        idle_inputs();
        sample();
        expect_val("issue_en_0", 64'(issue_en_0), 64'd1, 1'b0);
        expect_val("issue_info_0", 64'(issue_info_0), 64'(a.ops), 1'b0);
        @(posedge clk);
        finish_test("wakeup releases blocked op", errors - start);

        // Test 3 runs random traffic with partial loopback of wake outputs
        start       = errors;
        wake_errors = 0;
        for (int c = 0; c < 2000; c++) begin
            en_ok = model_ready();
            enq_req_0  <= en_ok & 1'(rand_bits(1));
            enq_req_1  <= en_ok & 1'(rand_bits(1));
            inst_Ops_0 <= rand_op(4);
            inst_Ops_1 <= rand_op(4);
            w.wake_reg_0 = `PRF_TAG_LEN'(rand_bits(4));
            w.wake_en_0  = (rand_bits(2) == 0);
            w.wake_reg_1 = `PRF_TAG_LEN'(rand_bits(4));
            w.wake_en_1  = (rand_bits(2) == 0);
            if (rand_bits(2) == 0) begin
                w.wake_reg_1 = loop_reg_0;
                w.wake_en_1  = loop_en_0;
            end
            wake_Info <= w;
            flush     <= (rand_bits(6) == 0);
            sample();
            @(posedge clk);
        end
        idle_inputs();
        finish_test("random traffic", errors - start);
        finish_test("wake outputs", wake_errors);

        // Test 4 fills with blocked ops and drains two per cycle
        start = errors;
        flush <= 1'b1;
        sample();
        @(posedge clk);
        flush <= 1'b0;
        n = 0;
        while (model_ready() && n < TIMEOUT) begin
            a = rand_op(6);
            b = rand_op(6);
            a.ops.src1PAddr = 6'd50;
            b.ops.src1PAddr = 6'd50;
            a.src1_rdy = 1'b0;
            b.src1_rdy = 1'b0;
            a.src2_rdy = 1'b1;
            b.src2_rdy = 1'b1;
            inst_Ops_0 <= a;
            inst_Ops_1 <= b;
            enq_req_0  <= 1'b1;
            enq_req_1  <= 1'b1;
            sample();
            @(posedge clk);
            n++;
        end
        idle_inputs();
        if (n >= TIMEOUT) begin
            errors++;
            $display("Timeout: ready never dropped while filling the queue");
        end
        sample();
        expect_val("ready", 64'(ready), 64'd0, 1'b0);
        @(posedge clk);
        w = '0;
        w.wake_reg_0 = 6'd50;
        w.wake_en_0  = 1'b1;
        wake_Info <= w;
        sample();
        @(posedge clk);
        idle_inputs();
        n     = 0;
        pairs = 0;
        while (m_valid != '0 && n < TIMEOUT) begin
            sample();
            if (issue_en_0 && issue_en_1) pairs++;
            @(posedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            errors++;
            $display("Timeout: queue did not drain");
        end
        sample();
        expect_val("drain_pairs", 64'(pairs), 64'(N / 2), 1'b0);
        expect_val("ready", 64'(ready), 64'd1, 1'b0);
        @(posedge clk);
        finish_test("full queue and drain", errors - start);

        // Test 5 flushes queued and same-cycle ops
        start = errors;
        a = rand_op(6);
        b = rand_op(6);
        a.ops.src1PAddr = 6'd55;
        a.ops.src2PAddr = 6'd56;
        a.src1_rdy = 1'b0;
        a.src2_rdy = 1'b0;
        b.src1_rdy = 1'b1;
        b.src2_rdy = 1'b1;
        inst_Ops_0 <= a;
        inst_Ops_1 <= b;
        enq_req_0  <= 1'b1;
        enq_req_1  <= 1'b1;
        sample();
        @(posedge clk);
        idle_inputs();
        inst_Ops_0 <= b;
        enq_req_0  <= 1'b1;   // Dropped by the flush
        flush      <= 1'b1;
        sample();
        expect_val("issue_en_0", 64'(issue_en_0), 64'd0, 1'b0);
        expect_val("issue_en_1", 64'(issue_en_1), 64'd0, 1'b0);
        @(posedge clk);
        idle_inputs();
        w = '0;
        w.wake_reg_0 = 6'd55;
        w.wake_en_0  = 1'b1;
        w.wake_reg_1 = 6'd56;
        w.wake_en_1  = 1'b1;
        wake_Info <= w;
        sample();
        expect_val("ready", 64'(ready), 64'd1, 1'b0);
        @(posedge clk);
        idle_inputs();
        repeat (4) begin
            sample();
            expect_val("issue_en_0", 64'(issue_en_0), 64'd0, 1'b0);
            @(posedge clk);
        end
        finish_test("flush", errors - start);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/issue_pkg.sv
hdl/issue_arbiter_8.sv
hdl/iq_alu.sv
hdl/issue_alu.sv
verification/issue_alu_chk.sv
verification/issue_alu_tb.sv
